/* common/riskyPkg.sv */
// shared widths, enums and stage bundles; xlen is fixed at 32 and the core has no data memory.
package riskyPkg;

  localparam int xlen = 32;
  localparam int imemDepth = 256;
  localparam int imemAddrW = 8;
  // sysclk cycles per uart bit.
  localparam int clocksPerBit = 8;

  typedef enum logic [2:0] {
    add,
    sub,
    andOp,
    orOp,
    xorOp,
    slt,
    passB
  } aluOpE;

  typedef enum logic [2:0] {
    aluReg,
    aluImm,
    lui,
    branchEq,
    branchNe,
    jal,
    store,
    illegal
  } instrKindE;

  typedef enum logic [1:0] {
    regFile,
    fromMem,
    fromWb
  } fwdSelE;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
  } fetchOutT;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    instrKindE       kind;
    aluOpE           aluOp;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1Value;
    logic [xlen-1:0] rs2Value;
    logic [xlen-1:0] imm;
    logic            writesRd;
  } decodeOutT;

  typedef struct packed {
    logic            valid;
    instrKindE       kind;
    logic [4:0]      rd;
    logic            writesRd;
    logic [xlen-1:0] result;
    logic [xlen-1:0] storeData;
  } executeOutT;

  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [xlen-1:0] value;
  } writebackT;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } redirectT;

endpackage

/* core/decodeStage.sv */
// rv32i subset decoder; anything outside the subset decodes to illegal and runs as a no-op.
`timescale 1ns/1ps

module decodeStage (
  input  logic                      sysclk,
  input  logic                      rstN,
  input  logic                      stall,
  input  logic                      flush,
  input  riskyPkg::fetchOutT        fetchIn,
  output logic [4:0]                rs1Addr,
  output logic [4:0]                rs2Addr,
  input  logic [riskyPkg::xlen-1:0] rs1Data,
  input  logic [riskyPkg::xlen-1:0] rs2Data,
  output riskyPkg::decodeOutT       decodeOut
);

  typedef enum logic [6:0] {
    opReg    = 7'b0110011,
    opImm    = 7'b0010011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111,
    opStore  = 7'b0100011
  } opcodeE;

  logic [riskyPkg::xlen-1:0] instr;
  opcodeE                    opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  riskyPkg::decodeOutT       decoded;

  assign instr = fetchIn.instr;
  assign opcode = opcodeE'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // while stalled, re-read the operands of the held instruction so that a
  // writeback retiring during the stall is not lost.
  assign rs1Addr = stall ? decodeOut.rs1 : instr[19:15];
  assign rs2Addr = stall ? decodeOut.rs2 : instr[24:20];

  always_comb begin
    decoded.valid = fetchIn.valid && !flush;
    decoded.pc = fetchIn.pc;
    decoded.rs1 = instr[19:15];
    decoded.rs2 = instr[24:20];
    decoded.rd = instr[11:7];
    decoded.rs1Value = rs1Data;
    decoded.rs2Value = rs2Data;
    decoded.kind = riskyPkg::illegal;
    decoded.aluOp = riskyPkg::add;
    decoded.imm = '0;
    case (opcode)
      opReg: begin
        decoded.kind = riskyPkg::aluReg;
        case ({funct7, funct3})
          10'b0000000_000: decoded.aluOp = riskyPkg::add;
          10'b0100000_000: decoded.aluOp = riskyPkg::sub;
          10'b0000000_111: decoded.aluOp = riskyPkg::andOp;
          10'b0000000_110: decoded.aluOp = riskyPkg::orOp;
          10'b0000000_100: decoded.aluOp = riskyPkg::xorOp;
          10'b0000000_010: decoded.aluOp = riskyPkg::slt;
          default: decoded.kind = riskyPkg::illegal;
        endcase
      end
      opImm: begin
        decoded.kind = (funct3 == 3'b000) ? riskyPkg::aluImm : riskyPkg::illegal;
        decoded.imm = {{20{instr[31]}}, instr[31:20]};
      end
      opLui: begin
        decoded.kind = riskyPkg::lui;
        decoded.aluOp = riskyPkg::passB;
        decoded.imm = {instr[31:12], 12'b0};
      end
      opBranch: begin
        if (funct3 == 3'b000) begin
          decoded.kind = riskyPkg::branchEq;
        end else if (funct3 == 3'b001) begin
          decoded.kind = riskyPkg::branchNe;
        end
        decoded.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      opJal: begin
        decoded.kind = riskyPkg::jal;
        decoded.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      opStore: begin
        decoded.kind = (funct3 == 3'b010) ? riskyPkg::store : riskyPkg::illegal;
        decoded.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      default: decoded.kind = riskyPkg::illegal;
    endcase
    decoded.writesRd = decoded.kind inside {riskyPkg::aluReg, riskyPkg::aluImm, riskyPkg::lui,
                                            riskyPkg::jal};
  end

  always_ff @(posedge sysclk) begin
    if (!rstN) begin
      decodeOut.valid <= 1'b0;
    end else if (stall) begin
      decodeOut.rs1Value <= rs1Data;
      decodeOut.rs2Value <= rs2Data;
    end else begin
      decodeOut <= decoded;
    end
  end

endmodule

/* core/executeStage.sv */
// alu, forwarding muxes and branch resolution; redirect is combinational and only for valid slots.
`timescale 1ns/1ps

module executeStage (
  input  logic                 sysclk,
  input  logic                 rstN,
  input  logic                 stall,
  input  riskyPkg::decodeOutT  decodeIn,
  input  riskyPkg::fwdSelE     fwdSelA,
  input  riskyPkg::fwdSelE     fwdSelB,
  input  riskyPkg::executeOutT memFwd,
  input  riskyPkg::writebackT  wbFwd,
  output riskyPkg::executeOutT executeOut,
  output riskyPkg::redirectT   redirect
);

  logic [riskyPkg::xlen-1:0] rs1Fwd;
  logic [riskyPkg::xlen-1:0] rs2Fwd;
  logic [riskyPkg::xlen-1:0] aluB;
  logic [riskyPkg::xlen-1:0] aluResult;
  logic [riskyPkg::xlen-1:0] result;
  logic                      condMet;

  function automatic logic [riskyPkg::xlen-1:0] forward(
    input riskyPkg::fwdSelE          sel,
    input logic [riskyPkg::xlen-1:0] regValue,
    input riskyPkg::executeOutT      mem,
    input riskyPkg::writebackT       wbIn
  );
    case (sel)
      riskyPkg::fromMem: return mem.result;
      riskyPkg::fromWb:  return wbIn.value;
      default:           return regValue;
    endcase
  endfunction

  assign rs1Fwd = forward(fwdSelA, decodeIn.rs1Value, memFwd, wbFwd);
  assign rs2Fwd = forward(fwdSelB, decodeIn.rs2Value, memFwd, wbFwd);
  assign aluB = (decodeIn.kind == riskyPkg::aluReg) ? rs2Fwd : decodeIn.imm;

  always_comb begin
    case (decodeIn.aluOp)
      riskyPkg::add:   aluResult = rs1Fwd + aluB;
      riskyPkg::sub:   aluResult = rs1Fwd - aluB;
      riskyPkg::andOp: aluResult = rs1Fwd & aluB;
      riskyPkg::orOp:  aluResult = rs1Fwd | aluB;
      riskyPkg::xorOp: aluResult = rs1Fwd ^ aluB;
      riskyPkg::slt:   aluResult = riskyPkg::xlen'($signed(rs1Fwd) < $signed(aluB));
      default:         aluResult = aluB;
    endcase
  end

  // jal links pc+4.
  assign result = (decodeIn.kind == riskyPkg::jal) ? decodeIn.pc + riskyPkg::xlen'(4) : aluResult;

  always_comb begin
    case (decodeIn.kind)
      riskyPkg::branchEq: condMet = (rs1Fwd == rs2Fwd);
      riskyPkg::branchNe: condMet = (rs1Fwd != rs2Fwd);
      riskyPkg::jal:      condMet = 1'b1;
      default:            condMet = 1'b0;
    endcase
  end

  assign redirect.taken = decodeIn.valid && condMet;
  assign redirect.target = decodeIn.pc + decodeIn.imm;

  always_ff @(posedge sysclk) begin
    if (!rstN) begin
      executeOut.valid <= 1'b0;
    end else if (!stall) begin
      executeOut.valid <= decodeIn.valid;
      executeOut.kind <= decodeIn.kind;
      executeOut.rd <= decodeIn.rd;
      executeOut.writesRd <= decodeIn.writesRd;
      executeOut.result <= result;
      executeOut.storeData <= rs2Fwd;
    end
  end

endmodule

/* core/fetchStage.sv */
// pc and instruction memory; the load port only writes while rstN is low, and pc wraps in imem.
`timescale 1ns/1ps

module fetchStage (
  input  logic                           sysclk,
  input  logic                           rstN,
  input  logic                           progWe,
  input  logic [riskyPkg::imemAddrW-1:0] progAddr,
  input  logic [riskyPkg::xlen-1:0]      progData,
  input  logic                           stall,
  input  logic                           flush,
  input  riskyPkg::redirectT             redirect,
  output riskyPkg::fetchOutT             fetchOut
);

  logic [riskyPkg::xlen-1:0] imem [riskyPkg::imemDepth];
  logic [riskyPkg::xlen-1:0] pc;

  // program load port.
  always_ff @(posedge sysclk) begin
    if (!rstN && progWe) begin
      imem[progAddr] <= progData;
    end
  end

  always_ff @(posedge sysclk) begin
    if (!rstN) begin
      pc <= '0;
      fetchOut.valid <= 1'b0;
    end else if (!stall) begin
      if (redirect.taken) begin
        pc <= redirect.target;
      end else begin
        pc <= pc + riskyPkg::xlen'(4);
      end
      // flushed slot becomes a bubble.
      fetchOut.valid <= !flush;
      fetchOut.pc <= pc;
      fetchOut.instr <= imem[pc[riskyPkg::imemAddrW+1:2]];
    end
  end

endmodule

/* core/memoryAccessStage.sv */
// store-to-uart stage; every sw sends rs2[7:0] regardless of address and stalls while busy.
`timescale 1ns/1ps

module memoryAccessStage (
  input  logic                 sysclk,
  input  logic                 rstN,
  input  riskyPkg::executeOutT executeIn,
  input  logic                 busy,
  output riskyPkg::executeOutT memFwd,
  output riskyPkg::writebackT  wb,
  output logic                 txWrite,
  output logic [7:0]           txByte,
  output logic                 uartStall
);

  logic isStore;

  assign isStore = executeIn.valid && (executeIn.kind == riskyPkg::store);

  // the store waits here until the transmitter frees up.
  assign uartStall = isStore && busy;
  assign txWrite = isStore && !busy;
  assign txByte = executeIn.storeData[7:0];

  assign memFwd = executeIn;

  always_ff @(posedge sysclk) begin
    if (!rstN) begin
      wb.valid <= 1'b0;
    end else begin
      // bubble into writeback during a uart stall.
      wb.valid <= executeIn.valid && executeIn.writesRd && !uartStall;
      wb.rd <= executeIn.rd;
      wb.value <= executeIn.result;
    end
  end

endmodule

/* core/registerFile.sv */
// 32 x xlen registers, cleared by reset; x0 reads zero and a same-cycle write is seen by reads.
`timescale 1ns/1ps

module registerFile (
  input  logic                      sysclk,
  input  logic                      rstN,
  input  logic [4:0]                rs1Addr,
  input  logic [4:0]                rs2Addr,
  output logic [riskyPkg::xlen-1:0] rs1Data,
  output logic [riskyPkg::xlen-1:0] rs2Data,
  input  riskyPkg::writebackT       wb
);

  logic [riskyPkg::xlen-1:0] regs [32];

  function automatic logic [riskyPkg::xlen-1:0] readPort(
    input logic [4:0]                addr,
    input logic [riskyPkg::xlen-1:0] stored,
    input riskyPkg::writebackT       wbIn
  );
    if (addr == 5'd0) begin
      return '0;
    end else if (wbIn.valid && wbIn.rd == addr) begin
      return wbIn.value;
    end
    return stored;
  endfunction

  assign rs1Data = readPort(rs1Addr, regs[rs1Addr], wb);
  assign rs2Data = readPort(rs2Addr, regs[rs2Addr], wb);

  always_ff @(posedge sysclk) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.value;
    end
  end

endmodule

/* hw/hazardController.sv */
// combinational stall, flush and forwarding control; there are no load-use stalls in this core.
`timescale 1ns/1ps

module hazardController (
  input  riskyPkg::decodeOutT  decodeOut,
  input  riskyPkg::executeOutT memFwd,
  input  riskyPkg::writebackT  wb,
  input  riskyPkg::redirectT   redirect,
  input  logic                 uartStall,
  output riskyPkg::fwdSelE     fwdSelA,
  output riskyPkg::fwdSelE     fwdSelB,
  output logic                 stall,
  output logic                 flush
);

  // memory stage wins over writeback, x0 never forwards.
  function automatic riskyPkg::fwdSelE pickSource(
    input logic [4:0]           rs,
    input riskyPkg::executeOutT mem,
    input riskyPkg::writebackT  wbIn
  );
    if (rs == 5'd0) begin
      return riskyPkg::regFile;
    end else if (mem.valid && mem.writesRd && mem.rd == rs) begin
      return riskyPkg::fromMem;
    end else if (wbIn.valid && wbIn.rd == rs) begin
      return riskyPkg::fromWb;
    end
    return riskyPkg::regFile;
  endfunction

  assign fwdSelA = pickSource(decodeOut.rs1, memFwd, wb);
  assign fwdSelB = pickSource(decodeOut.rs2, memFwd, wb);

  assign stall = uartStall;
  // a held branch is redirected once the stall lifts.
  assign flush = redirect.taken && !uartStall;

endmodule

/* hw/risky.sv */
// risky core top; load the program while rstN is low, and the only visible output is the uart line.
`timescale 1ns/1ps

module risky (
  input  logic                           sysclk,
  input  logic                           rstN,
  input  logic                           progWe,
  input  logic [riskyPkg::imemAddrW-1:0] progAddr,
  input  logic [riskyPkg::xlen-1:0]      progData,
  output logic                           uartTx
);

  riskyPkg::fetchOutT   fetchOut;
  riskyPkg::decodeOutT  decodeOut;
  riskyPkg::executeOutT executeOut;
  riskyPkg::executeOutT memFwd;
  riskyPkg::writebackT  wb;
  riskyPkg::redirectT   redirect;
  riskyPkg::fwdSelE     fwdSelA;
  riskyPkg::fwdSelE     fwdSelB;

  logic                       stall;
  logic                       flush;
  logic                       uartStall;
  logic [4:0]                 rs1Addr;
  logic [4:0]                 rs2Addr;
  logic [riskyPkg::xlen-1:0]  rs1Data;
  logic [riskyPkg::xlen-1:0]  rs2Data;
  logic                       txWrite;
  logic [7:0]                 txByte;
  logic                       busy;

  fetchStage fetchStageInst (
    .sysclk(sysclk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .stall(stall), .flush(flush), .redirect(redirect), .fetchOut(fetchOut)
  );

  decodeStage decodeStageInst (
    .sysclk(sysclk), .rstN(rstN), .stall(stall), .flush(flush), .fetchIn(fetchOut),
    .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rs1Data(rs1Data), .rs2Data(rs2Data),
    .decodeOut(decodeOut)
  );

  registerFile registerFileInst (
    .sysclk(sysclk), .rstN(rstN), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
    .rs1Data(rs1Data), .rs2Data(rs2Data), .wb(wb)
  );

  executeStage executeStageInst (
    .sysclk(sysclk), .rstN(rstN), .stall(stall), .decodeIn(decodeOut),
    .fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .memFwd(memFwd), .wbFwd(wb),
    .executeOut(executeOut), .redirect(redirect)
  );

  memoryAccessStage memoryAccessStageInst (
    .sysclk(sysclk), .rstN(rstN), .executeIn(executeOut), .busy(busy), .memFwd(memFwd),
    .wb(wb), .txWrite(txWrite), .txByte(txByte), .uartStall(uartStall)
  );

  hazardController hazardControllerInst (
    .decodeOut(decodeOut), .memFwd(memFwd), .wb(wb), .redirect(redirect),
    .uartStall(uartStall), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .stall(stall), .flush(flush)
  );

  uartTx uartTxInst (
    .sysclk(sysclk), .rstN(rstN), .write(txWrite), .data(txByte), .busy(busy), .tx(uartTx)
  );

endmodule

/* src.f */
common/riskyPkg.sv
uart/uartTx.sv
core/registerFile.sv
core/fetchStage.sv
core/decodeStage.sv
core/executeStage.sv
core/memoryAccessStage.sv
hw/hazardController.sv
hw/risky.sv
tests/uartChecker.sv
tests/tbRisky.sv

/* tests/tbRisky.sv */
// random programs over x0..x7 with forward-only branches; imem words past the halt are never loaded.
`timescale 1ns/1ps

module tbRisky;

  typedef enum {genSw, genReg, genAddi, genLui, genBeq, genBne, genJal} genKindE;

  localparam int programCount = 8;
  localparam int instrCount = 40;
  localparam int haltIndex = instrCount - 1;
  localparam int resetCycles = 4;
  localparam int frameCycles = 10 * riskyPkg::clocksPerBit;
  localparam int timeoutCycles =
    programCount * (instrCount * 12 + instrCount * frameCycles * 2);

  logic                           sysclk;
  logic                           rstN;
  logic                           progWe;
  logic [riskyPkg::imemAddrW-1:0] progAddr;
  logic [riskyPkg::xlen-1:0]      progData;
  logic                           uartLine;
  logic                           expPush;
  logic [7:0]                     expByte;
  int                             pendingCount;
  logic                           inFrame;
  int                             frameErrors;
  int                             dataErrors;
  int                             missingErrors;

  genKindE     kinds [instrCount];
  int          dstReg [instrCount];
  int          srcA [instrCount];
  int          srcB [instrCount];
  int          aluSel [instrCount];
  int          immVal [instrCount];
  logic [31:0] words [instrCount];
  logic [7:0]  expBytes [$];
  int          seed = 32'h61c;
  int          totalBytes = 0;

  risky risky_i (
    .sysclk(sysclk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr),
    .progData(progData), .uartTx(uartLine)
  );

  uartChecker byteChecker (
    .sysclk(sysclk), .rstN(rstN), .tx(uartLine), .expPush(expPush), .expByte(expByte),
    .pendingCount(pendingCount), .inFrame(inFrame), .frameErrors(frameErrors),
    .dataErrors(dataErrors), .missingErrors(missingErrors)
  );

  initial begin
    sysclk = 1'b0;
    forever #10 sysclk = ~sysclk;
  end

  function automatic int randBelow(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // rv32i field packing for the generated subset.
  function automatic logic [31:0] encode(int i);
    logic [31:0] v;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  a;
    logic [4:0]  b;
    v = immVal[i];
    rd = 5'(dstReg[i]);
    a = 5'(srcA[i]);
    b = 5'(srcB[i]);
    case (aluSel[i])
      0, 1: f3 = 3'b000;
      2: f3 = 3'b111;
      3: f3 = 3'b110;
      4: f3 = 3'b100;
      default: f3 = 3'b010;
    endcase
    case (kinds[i])
      genReg: return {(aluSel[i] == 1) ? 7'h20 : 7'h00, b, a, f3, rd, 7'b0110011};
      genAddi: return {v[11:0], a, 3'b000, rd, 7'b0010011};
      genLui: return {v[19:0], rd, 7'b0110111};
      genSw: return {v[11:5], b, a, 3'b010, v[4:0], 7'b0100011};
      genBeq: return {v[12], v[10:5], b, a, 3'b000, v[4:1], v[11], 7'b1100011};
      genBne: return {v[12], v[10:5], b, a, 3'b001, v[4:1], v[11], 7'b1100011};
      default: return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
    endcase
  endfunction

  task automatic genProgram();
    int pick;
    int span;
    for (int i = 0; i < haltIndex; i++) begin
      pick = randBelow(16);
      span = 2 + randBelow(3);
      if (i + span > haltIndex) begin
        span = haltIndex - i;
      end
      dstReg[i] = randBelow(8);
      srcA[i] = randBelow(8);
      srcB[i] = randBelow(8);
      aluSel[i] = randBelow(6);
      immVal[i] = randBelow(4096) - 2048;
      case (pick)
        0, 1, 2, 3: kinds[i] = genSw;
        4, 5, 6, 7, 8: kinds[i] = genReg;
        9, 10: kinds[i] = genAddi;
        11: kinds[i] = genLui;
        12, 13: kinds[i] = genBeq;
        14: kinds[i] = genBne;
        default: kinds[i] = genJal;
      endcase
      if (kinds[i] == genLui) begin
        immVal[i] = randBelow(1 << 20);
      end
      if (kinds[i] inside {genBeq, genBne, genJal}) begin
        immVal[i] = span * 4;
      end
      words[i] = encode(i);
    end
    // jal x0, 0 parks the core.
    kinds[haltIndex] = genJal;
    dstReg[haltIndex] = 0;
    immVal[haltIndex] = 0;
    words[haltIndex] = encode(haltIndex);
  endtask

  // sequential isa interpreter, collects the store bytes in order.
  task automatic runModel();
    logic [31:0] x [8];
    int          pc;
    int          a;
    int          b;
    for (int r = 0; r < 8; r++) begin
      x[r] = '0;
    end
    pc = 0;
    expBytes.delete();
    while (pc != haltIndex) begin
      a = srcA[pc];
      b = srcB[pc];
      case (kinds[pc])
        genReg: begin
          case (aluSel[pc])
            0: x[dstReg[pc]] = x[a] + x[b];
            1: x[dstReg[pc]] = x[a] - x[b];
            2: x[dstReg[pc]] = x[a] & x[b];
            3: x[dstReg[pc]] = x[a] | x[b];
            4: x[dstReg[pc]] = x[a] ^ x[b];
            default: x[dstReg[pc]] = ($signed(x[a]) < $signed(x[b])) ? 32'd1 : 32'd0;
          endcase
          pc++;
        end
        genAddi: begin
          x[dstReg[pc]] = x[a] + 32'(immVal[pc]);
          pc++;
        end
        genLui: begin
          x[dstReg[pc]] = 32'(immVal[pc]) << 12;
          pc++;
        end
        genSw: begin
          expBytes.push_back(x[b][7:0]);
          pc++;
        end
        genBeq: pc += (x[a] == x[b]) ? immVal[pc] / 4 : 1;
        genBne: pc += (x[a] != x[b]) ? immVal[pc] / 4 : 1;
        default: begin
          x[dstReg[pc]] = 32'(pc * 4 + 4);
          pc += immVal[pc] / 4;
        end
      endcase
      x[0] = '0;
    end
  endtask

  // program and expected bytes go in together while the core sits in reset.
  task automatic loadProgram();
    @(posedge sysclk);
    rstN <= 1'b0;
    for (int j = 0; j < instrCount; j++) begin
      @(posedge sysclk);
      progWe <= 1'b1;
      progAddr <= j[riskyPkg::imemAddrW-1:0];
      progData <= words[j];
      expPush <= (j < expBytes.size());
      expByte <= (j < expBytes.size()) ? expBytes[j] : 8'h00;
    end
    @(posedge sysclk);
    progWe <= 1'b0;
    expPush <= 1'b0;
    repeat (resetCycles) @(posedge sysclk);
    rstN <= 1'b1;
  endtask

  initial begin
    rstN = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    expPush = 1'b0;
    expByte = '0;
    for (int p = 0; p < programCount; p++) begin
      genProgram();
      runModel();
      loadProgram();
      totalBytes += expBytes.size();
      while (pendingCount != 0) @(posedge sysclk);
      // room for a stray extra frame to show up.
      repeat (2 * frameCycles) @(posedge sysclk);
      while (inFrame) @(posedge sysclk);
    end
    @(posedge sysclk);
    rstN <= 1'b0;
    repeat (2) @(posedge sysclk);
    $display("closing: %0d programs, %0d bytes, framing errors %0d, data errors %0d, missing %0d",
             programCount, totalBytes, frameErrors, dataErrors, missingErrors);
    if (frameErrors + dataErrors + missingErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat (timeoutCycles) @(posedge sysclk);
    $display("timeout after %0d cycles with %0d uart bytes still outstanding",
             timeoutCycles, pendingCount);
    $display("sim failed");
    $finish;
  end

endmodule

/* tests/uartChecker.sv */
// 8N1 receiver at clocksPerBit cycles per bit; the line must be idle whenever reset is entered.
`timescale 1ns/1ps

module uartChecker (
  input  logic       sysclk,
  input  logic       rstN,
  input  logic       tx,
  input  logic       expPush,
  input  logic [7:0] expByte,
  output int         pendingCount,
  output logic       inFrame,
  output int         frameErrors,
  output int         dataErrors,
  output int         missingErrors
);

  logic [7:0] expected [$];
  logic       wasInReset = 1'b0;
  logic       lineSettled = 1'b0;

  initial begin
    pendingCount = 0;
    inFrame = 1'b0;
    frameErrors = 0;
    dataErrors = 0;
    missingErrors = 0;
  end

  // queue side; entering reset drops whatever never arrived.
  always @(posedge sysclk) begin
    if (!rstN && !wasInReset && expected.size() != 0) begin
      $display("missing %0d uart bytes when reset was entered at %0t", expected.size(), $time);
      missingErrors += expected.size();
      expected.delete();
    end
    if (expPush) begin
      expected.push_back(expByte);
    end
    pendingCount <= expected.size();
    wasInReset = !rstN;
  end

  task automatic receiveFrame();
    logic [7:0] data;
    logic [7:0] want;
    // land on the middle of the start bit.
    repeat (riskyPkg::clocksPerBit / 2 - 1) @(posedge sysclk);
    if (tx !== 1'b0) begin
      $display("framing error at %0t: start bit did not stay low to its midpoint", $time);
      frameErrors++;
      return;
    end
    for (int b = 0; b < 8; b++) begin
      repeat (riskyPkg::clocksPerBit) @(posedge sysclk);
      data[b] = tx;
    end
    repeat (riskyPkg::clocksPerBit) @(posedge sysclk);
    if (tx !== 1'b1) begin
      $display("framing error at %0t: stop bit was not high", $time);
      frameErrors++;
    end
    if (expected.size() == 0) begin
      $display("unexpected uart byte %h at %0t with nothing pending", data, $time);
      dataErrors++;
    end else begin
      want = expected.pop_front();
      if (data !== want) begin
        $display("error at %0t: uartTx byte got %h expected %h", $time, data, want);
        dataErrors++;
      end
    end
  endtask

  always @(posedge sysclk) begin
    if (!rstN) begin
      if (lineSettled && tx !== 1'b1) begin
        $display("error at %0t: uartTx got %b expected 1 during reset", $time, tx);
        frameErrors++;
      end
    end else if (tx === 1'b0) begin
      inFrame <= 1'b1;
      receiveFrame();
      inFrame <= 1'b0;
    end
    lineSettled = !rstN;
  end

endmodule

/* uart/uartTx.sv */
// 8N1 transmitter, clocksPerBit sysclk cycles per bit; write is ignored while busy is high.
`timescale 1ns/1ps

module uartTx (
  input  logic       sysclk,
  input  logic       rstN,
  input  logic       write,
  input  logic [7:0] data,
  output logic       busy,
  output logic       tx
);

  logic [9:0]                                 shifter;
  logic [3:0]                                 bitsLeft;
  logic [$clog2(riskyPkg::clocksPerBit)-1:0]  tickCount;

  // line idles high since the shifter fills with ones.
  assign tx = shifter[0];

  always_ff @(posedge sysclk) begin
    if (!rstN) begin
      shifter <= '1;
      busy <= 1'b0;
      bitsLeft <= '0;
      tickCount <= '0;
    end else if (!busy) begin
      if (write) begin
        // stop, data lsb first, start.
        shifter <= {1'b1, data, 1'b0};
        busy <= 1'b1;
        bitsLeft <= 4'd10;
        tickCount <= '0;
      end
    end else if (int'(tickCount) == riskyPkg::clocksPerBit - 1) begin
      tickCount <= '0;
      shifter <= {1'b1, shifter[9:1]};
      bitsLeft <= bitsLeft - 4'd1;
      if (bitsLeft == 4'd1) begin
        busy <= 1'b0;
      end
    end else begin
      tickCount <= tickCount + 1'b1;
    end
  end

endmodule
